//--- branchCore.f
hw/branchCorePkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/axiLiteControl.sv
hw/branchCore.sv
sim/branchCore_sva.sv
sim/branchCoreTb.sv

//--- hw/axiLiteControl.sv
`timescale 1ns/1ns
`default_nettype none

module axiLiteControl import branchCorePkg::*; (
    input  logic                   Clock,
    input  logic                   reset,
    input  axiLiteReq_t            axiReq,
    output axiLiteRsp_t            axiRsp,
    output memWrite_t              memWrite,
    output logic                   startPulse,
    output logic                   running,
    input  logic                   haltSeen,
    input  logic [memAddrBits-1:0] pc,
    output logic [regAddrBits-1:0] regReadIndex,
    input  logic [dataWidth-1:0]   regReadData
);

    logic                 writeAccept;
    logic                 readAccept;
    logic                 bvalidReg;
    logic                 arreadyReg;
    logic                 rvalidReg;
    logic                 rvalidNext;
    logic [dataWidth-1:0] rdataReg;
    logic [dataWidth-1:0] readMux;
    logic                 halted;

    // Address and data taken together, one write in flight
    assign writeAccept = axiReq.awvalid && axiReq.wvalid && !bvalidReg;
    assign readAccept  = axiReq.arvalid && arreadyReg;

    assign memWrite = '{
        valid: writeAccept && (axiReq.awaddr < ctrlAddr),
        addr:  axiReq.awaddr[memAddrBits+1:2],   // Byte address to word
        data:  axiReq.wdata
    };

    assign startPulse = writeAccept && (axiReq.awaddr == ctrlAddr) && axiReq.wdata[0];

    always_ff @(posedge Clock) begin
        if (reset) begin
            bvalidReg <= 1'b0;
        end else if (writeAccept) begin
            bvalidReg <= 1'b1;
        end else if (axiReq.bready) begin
            bvalidReg <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (startPulse) begin
            running <= 1'b1;
            halted  <= 1'b0;
        end else if (haltSeen) begin
            running <= 1'b0;
            halted  <= 1'b1;
        end
    end

    assign regReadIndex = axiReq.araddr[regAddrBits+1:2];

    always_comb begin
        readMux = '0;   // Unmapped reads give zero
        if (axiReq.araddr == ctrlAddr) begin
            readMux[1:0] = {halted, running};
        end else if (axiReq.araddr == pcAddr) begin
            readMux[memAddrBits-1:0] = pc;
        end else if (axiReq.araddr[axiAddrBits-1:6] == regBase[axiAddrBits-1:6]) begin
            readMux = regReadData;
        end
    end

    assign rvalidNext = readAccept ? 1'b1 : (rvalidReg && !axiReq.rready);

    always_ff @(posedge Clock) begin
        if (reset) begin
            rvalidReg  <= 1'b0;
            arreadyReg <= 1'b0;
        end else begin
            rvalidReg  <= rvalidNext;
            arreadyReg <= !rvalidNext;   // Reopen once the response is taken
        end
    end

    always_ff @(posedge Clock) begin
        if (readAccept) begin
            rdataReg <= readMux;         // Held until rready
        end
    end

    assign axiRsp = '{
        awready: writeAccept,
        wready:  writeAccept,
        bvalid:  bvalidReg,
        bresp:   2'b00,
        arready: arreadyReg,
        rvalid:  rvalidReg,
        rdata:   rdataReg,
        rresp:   2'b00
    };

endmodule

`default_nettype wire

//--- hw/branchCore.sv
`timescale 1ns/1ns
`default_nettype none

module branchCore import branchCorePkg::*; (
    input  logic        Clock,
    input  logic        reset,
    input  axiLiteReq_t axiReq,
    output axiLiteRsp_t axiRsp
);

    memWrite_t              memWrite;
    logic                   startPulse;
    logic                   running;
    logic                   haltSeen;
    logic [memAddrBits-1:0] pc;
    logic [regAddrBits-1:0] regReadIndex;
    logic [dataWidth-1:0]   regReadData;
    fetchToDecode_t         fetchOut;
    decodeToExecute_t       decodeOut;
    writeback_t             writeback;
    redirect_t              redirect;

    axiLiteControl axiLiteControl_i (
        .Clock        (Clock),
        .reset        (reset),
        .axiReq       (axiReq),
        .axiRsp       (axiRsp),
        .memWrite     (memWrite),
        .startPulse   (startPulse),
        .running      (running),
        .haltSeen     (haltSeen),
        .pc           (pc),
        .regReadIndex (regReadIndex),
        .regReadData  (regReadData)
    );

    fetchStage fetchStage_i (
        .Clock      (Clock),
        .reset      (reset),
        .memWrite   (memWrite),
        .startPulse (startPulse),
        .running    (running),
        .redirect   (redirect),
        .fetchOut   (fetchOut),
        .pc         (pc)
    );

    decodeStage decodeStage_i (
        .Clock        (Clock),
        .reset        (reset),
        .fetchIn      (fetchOut),
        .redirect     (redirect),
        .writeback    (writeback),
        .decodeOut    (decodeOut),
        .regReadIndex (regReadIndex),
        .regReadData  (regReadData)
    );

    executeStage executeStage_i (
        .Clock     (Clock),
        .reset     (reset),
        .decodeIn  (decodeOut),
        .writeback (writeback),
        .redirect  (redirect),
        .haltSeen  (haltSeen)
    );

endmodule

`default_nettype wire

//--- hw/branchCorePkg.sv
`default_nettype none

package branchCorePkg;

    localparam int dataWidth   = 32;
    localparam int memWords    = 512;
    localparam int memAddrBits = 9;
    localparam int regCount    = 16;
    localparam int regAddrBits = 4;
    localparam int immBits     = 19;   // Signed constant C
    localparam int axiAddrBits = 12;

    localparam logic [axiAddrBits-1:0] ctrlAddr = 12'h800;  // W bit0 start, R bit0 run bit1 halt
    localparam logic [axiAddrBits-1:0] pcAddr   = 12'h804;
    localparam logic [axiAddrBits-1:0] regBase  = 12'h840;  // r0..r15 at 4-byte steps

    typedef enum logic [4:0] {
        opLdi    = 5'd1,
        opBranch = 5'd19,
        opNop    = 5'd26,
        opHalt   = 5'd27
    } opcode_t;

    typedef enum logic [1:0] {
        condZero,
        condNonzero,
        condPlus,      // Sign bit clear
        condMinus      // Sign bit set
    } cond_t;

    typedef struct packed {
        logic                   valid;
        logic [memAddrBits-1:0] pc;
        logic [dataWidth-1:0]   instr;
    } fetchToDecode_t;

    typedef struct packed {
        logic                   valid;
        opcode_t                opcode;
        logic [regAddrBits-1:0] ra;
        logic [memAddrBits-1:0] pc;
        logic [dataWidth-1:0]   base;     // rb value, zero for r0
        logic [dataWidth-1:0]   imm;      // Sign-extended C
        logic                   condMet;
    } decodeToExecute_t;

    typedef struct packed {
        logic                   valid;
        logic [regAddrBits-1:0] index;
        logic [dataWidth-1:0]   value;
    } writeback_t;

    typedef struct packed {
        logic                   valid;
        logic [memAddrBits-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                   valid;
        logic [memAddrBits-1:0] addr;
        logic [dataWidth-1:0]   data;
    } memWrite_t;

    typedef struct packed {
        logic                   awvalid;
        logic [axiAddrBits-1:0] awaddr;
        logic                   wvalid;
        logic [dataWidth-1:0]   wdata;
        logic [3:0]             wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [axiAddrBits-1:0] araddr;
        logic                   rready;
    } axiLiteReq_t;

    typedef struct packed {
        logic                 awready;
        logic                 wready;
        logic                 bvalid;
        logic [1:0]           bresp;
        logic                 arready;
        logic                 rvalid;
        logic [dataWidth-1:0] rdata;
        logic [1:0]           rresp;
    } axiLiteRsp_t;

endpackage

`default_nettype wire

//--- hw/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage import branchCorePkg::*; (
    input  logic                   Clock,
    input  logic                   reset,
    input  fetchToDecode_t         fetchIn,
    input  redirect_t              redirect,
    input  writeback_t             writeback,
    output decodeToExecute_t       decodeOut,
    input  logic [regAddrBits-1:0] regReadIndex,
    output logic [dataWidth-1:0]   regReadData
);

    logic [dataWidth-1:0]   regFile [regCount];
    logic [regAddrBits-1:0] raIdx;
    logic [regAddrBits-1:0] rbIdx;
    logic [dataWidth-1:0]   raValue;
    logic [dataWidth-1:0]   rbValue;
    cond_t                  cond;
    opcode_t                opcode;
    logic                   condMet;
    decodeToExecute_t       nextItem;

    // Execute result of this cycle wins over the stored value
    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrBits-1:0] idx);
        if (writeback.valid && writeback.index == idx) begin
            return writeback.value;
        end
        return regFile[idx];
    endfunction

    assign raIdx = fetchIn.instr[26:23];
    assign rbIdx = fetchIn.instr[22:19];
    assign cond  = cond_t'(fetchIn.instr[20:19]);  // Overlaps rb for branches

    always_comb begin
        raValue = readReg(raIdx);
        rbValue = readReg(rbIdx);
    end

    always_comb begin
        case (fetchIn.instr[31:27])
            opLdi, opBranch, opHalt: opcode = opcode_t'(fetchIn.instr[31:27]);
            default:                 opcode = opNop;  // Unknown codes retire quietly
        endcase
    end

    always_comb begin
        case (cond)
            condZero:    condMet = (raValue == '0);
            condNonzero: condMet = (raValue != '0);
            condPlus:    condMet = !raValue[dataWidth-1];
            default:     condMet = raValue[dataWidth-1];
        endcase
    end

    assign nextItem = '{
        valid:   fetchIn.valid,
        opcode:  opcode,
        ra:      raIdx,
        pc:      fetchIn.pc,
        base:    (rbIdx == '0) ? '0 : rbValue,
        imm:     {{(dataWidth-immBits){fetchIn.instr[immBits-1]}},
                  fetchIn.instr[immBits-1:0]},
        condMet: condMet
    };

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (writeback.valid) begin
            regFile[writeback.index] <= writeback.value;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset || redirect.valid) begin
            decodeOut <= '0;     // Younger item dies behind a taken branch
        end else begin
            decodeOut <= nextItem;
        end
    end

    assign regReadData = regFile[regReadIndex];  // Host readback

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage import branchCorePkg::*; (
    input  logic             Clock,
    input  logic             reset,
    input  decodeToExecute_t decodeIn,
    output writeback_t       writeback,
    output redirect_t        redirect,
    output logic             haltSeen
);

    logic                   live;
    logic                   isLdi;
    logic                   isTaken;
    logic [dataWidth-1:0]   ldiResult;
    logic [memAddrBits-1:0] branchTarget;

    // Fetch and decode already drop the items behind a redirect
    assign live = decodeIn.valid;

    assign isLdi    = live && (decodeIn.opcode == opLdi);
    assign isTaken  = live && (decodeIn.opcode == opBranch) && decodeIn.condMet;
    assign haltSeen = live && (decodeIn.opcode == opHalt);

    assign ldiResult    = decodeIn.base + decodeIn.imm;
    assign branchTarget = decodeIn.pc + memAddrBits'(1) + decodeIn.imm[memAddrBits-1:0];

    assign writeback = '{valid: isLdi, index: decodeIn.ra, value: ldiResult};

    // Halt points fetch back at itself so the PC parks on the halt
    assign redirect = '{
        valid:  isTaken || haltSeen,
        target: haltSeen ? decodeIn.pc : branchTarget
    };

endmodule

`default_nettype wire

//--- hw/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage import branchCorePkg::*; (
    input  logic                   Clock,
    input  logic                   reset,
    input  memWrite_t              memWrite,
    input  logic                   startPulse,
    input  logic                   running,
    input  redirect_t              redirect,
    output fetchToDecode_t         fetchOut,
    output logic [memAddrBits-1:0] pc
);

    logic [dataWidth-1:0]   instrMem [memWords];
    logic [dataWidth-1:0]   fetchWord;
    logic [memAddrBits-1:0] fetchPc;
    logic                   fetchValid;

    // Host port writes, pipeline reads one word per cycle
    always_ff @(posedge Clock) begin
        if (memWrite.valid) begin
            instrMem[memWrite.addr] <= memWrite.data;
        end
        fetchWord <= instrMem[pc];
        fetchPc   <= pc;   // Address of the word being read
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else if (startPulse) begin
            pc         <= '0;          // Program always starts at word 0
            fetchValid <= 1'b0;
        end else if (redirect.valid) begin
            pc         <= redirect.target;
            fetchValid <= 1'b0;        // Squash the word read this cycle
        end else if (running) begin
            pc         <= pc + 1'b1;
            fetchValid <= 1'b1;
        end else begin
            fetchValid <= 1'b0;        // Idle or halted, PC holds
        end
    end

    assign fetchOut = '{valid: fetchValid, pc: fetchPc, instr: fetchWord};

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build and run the branchCore testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module branchCoreTb \
    -f branchCore.f -o branchCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/branchCoreSim +verilator+error+limit+100)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- sim/branchCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module branchCoreTb import branchCorePkg::*; ();

    localparam int handshakeLimit = 50;    // Cycles per AXI wait
    localparam int pollLimit      = 500;   // Status reads per program

    logic        Clock;
    logic        reset;
    axiLiteReq_t axiReq;
    axiLiteRsp_t axiRsp;
    int          errorCount;
    int          timeoutCount;
    logic        runAborted;

    branchCore branchCore_i (
        .Clock  (Clock),
        .reset  (reset),
        .axiReq (axiReq),
        .axiRsp (axiRsp)
    );

    always #2 Clock = ~Clock;

    task automatic stepCycle();
        @(posedge Clock);
        #1;   // Inputs change here
    endtask

    function automatic logic [axiAddrBits-1:0] regAddr(input logic [31:0] index);
        return regBase + axiAddrBits'(index * 4);
    endfunction

    function automatic logic [axiAddrBits-1:0] memAddr(input logic [31:0] word);
        return axiAddrBits'(word * 4);   // Word index to byte address
    endfunction

    task automatic reportTimeout(input string what);
        timeoutCount++;
        runAborted = 1'b1;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
    endtask

    task automatic axiWrite(input logic [axiAddrBits-1:0] addr, input logic [31:0] data);
        int waited;
        int delay;
        if (runAborted) begin
            return;
        end
        axiReq.awvalid = 1'b1;
        axiReq.awaddr  = addr;
        axiReq.wvalid  = 1'b1;
        axiReq.wdata   = data;
        axiReq.wstrb   = 4'hf;
        waited = 0;
        @(negedge Clock);   // Outputs are settled mid-cycle
        while (!(axiRsp.awready && axiRsp.wready) && waited < handshakeLimit) begin
            @(negedge Clock);
            waited++;
        end
        if (!(axiRsp.awready && axiRsp.wready)) begin
            reportTimeout("awready and wready");
            return;
        end
        stepCycle();
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        delay = $urandom % 4;   // Back-pressure on the response
        repeat (delay) stepCycle();
        axiReq.bready = 1'b1;
        waited = 0;
        @(negedge Clock);
        while (!axiRsp.bvalid && waited < handshakeLimit) begin
            @(negedge Clock);
            waited++;
        end
        if (!axiRsp.bvalid) begin
            reportTimeout("bvalid");
            return;
        end
        if (axiRsp.bresp != 2'b00) begin
            errorCount++;
            $display("[ERROR] %0t: write to 0x%03h got bresp %0d", $time, addr, axiRsp.bresp);
        end
        stepCycle();
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [axiAddrBits-1:0] addr, output logic [31:0] data);
        int waited;
        int delay;
        data = '0;
        if (runAborted) begin
            return;
        end
        axiReq.arvalid = 1'b1;
        axiReq.araddr  = addr;
        waited = 0;
        @(negedge Clock);
        while (!axiRsp.arready && waited < handshakeLimit) begin
            @(negedge Clock);
            waited++;
        end
        if (!axiRsp.arready) begin
            reportTimeout("arready");
            return;
        end
        stepCycle();
        axiReq.arvalid = 1'b0;
        delay = $urandom % 4;
        repeat (delay) stepCycle();
        axiReq.rready = 1'b1;
        waited = 0;
        @(negedge Clock);
        while (!axiRsp.rvalid && waited < handshakeLimit) begin
            @(negedge Clock);
            waited++;
        end
        if (!axiRsp.rvalid) begin
            reportTimeout("rvalid");
            return;
        end
        data = axiRsp.rdata;
        if (axiRsp.rresp != 2'b00) begin
            errorCount++;
            $display("[ERROR] %0t: read of 0x%03h got rresp %0d", $time, addr, axiRsp.rresp);
        end
        stepCycle();
        axiReq.rready = 1'b0;
    endtask

    task automatic checkRead(input logic [axiAddrBits-1:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        axiRead(addr, got);
        if (!runAborted && got != expected) begin
            errorCount++;
            $display("[ERROR] %0t: addr 0x%03h expected 0x%08h read 0x%08h",
                     $time, addr, expected, got);
        end
    endtask

    // Start the program and poll the status until the halted bit shows
    task automatic startAndWait();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        axiWrite(ctrlAddr, 32'h1);
        while (!runAborted && !status[1] && polls < pollLimit) begin
            axiRead(ctrlAddr, status);
            polls++;
        end
        if (!runAborted && !status[1]) begin
            reportTimeout("the halted bit after start");
        end
    endtask

    task automatic runCommand(input logic [7:0] cmd, input logic [31:0] argA,
                              input logic [31:0] argB);
        case (cmd)
            "M": axiWrite(memAddr(argA), argB);
            "S": startAndWait();
            "C": checkRead(ctrlAddr, argB);
            "P": checkRead(pcAddr, argB);
            "R": checkRead(regAddr(argA), argB);
            default: begin
                $display("Unknown command '%c' in the test data file", cmd);
                runAborted = 1'b1;
            end
        endcase
    endtask

    initial begin
        int               fd;
        int               count;
        int               unused;
        logic             fileDone;
        logic [7:0]       cmd;
        logic [31:0]      argA;
        logic [31:0]      argB;
        logic [8*128-1:0] skipLine;
        Clock        = 1'b0;
        reset        = 1'b1;
        axiReq       = '0;
        errorCount   = 0;
        timeoutCount = 0;
        runAborted   = 1'b0;
        fileDone     = 1'b0;
        unused       = $urandom(32'h24ac);
        repeat (3) @(posedge Clock);
        #1;
        reset = 1'b0;

        // Idle core, PC at zero and a cleared register file
        checkRead(ctrlAddr, 32'h0);
        checkRead(pcAddr, 32'h0);
        for (int i = 0; i < regCount; i++) begin
            checkRead(regAddr(i), 32'h0);
        end

        fd = $fopen("sim/branchCore_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/branchCore_testdata.txt");
            runAborted = 1'b1;
        end
        while (!runAborted && !fileDone) begin
            count = $fscanf(fd, " %c", cmd);
            if (count != 1) begin
                fileDone = 1'b1;
            end else if (cmd == "#") begin
                unused = $fgets(skipLine, fd);   // Comment line
            end else begin
                count = $fscanf(fd, " %h %h", argA, argB);
                if (count != 2) begin
                    $display("Malformed line for command '%c' in the test data file", cmd);
                    runAborted = 1'b1;
                end else begin
                    runCommand(cmd, argA, argB);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
                 errorCount, timeoutCount, branchCore_i.branchCoreSva_i.failCount);
        if (errorCount == 0 && !runAborted && branchCore_i.branchCoreSva_i.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/branchCore_sva.sv
`timescale 1ns/1ns
`default_nettype none

module branchCoreSva import branchCorePkg::*; (
    input logic        Clock,
    input logic        reset,
    input axiLiteReq_t axiReq,
    input axiLiteRsp_t axiRsp,
    input redirect_t   redirect,
    input writeback_t  writeback
);

    int failCount = 0;

    bvalidHold: assert property (@(posedge Clock) disable iff (reset)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
    else begin
        $error("bvalid dropped before bready");
        failCount++;
    end

    // Read data must not move while the host holds off
    rdataStable: assert property (@(posedge Clock) disable iff (reset)
        axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        failCount++;
    end

    squashedNoWrite: assert property (@(posedge Clock) disable iff (reset)
        $past(redirect.valid) || $past(redirect.valid, 2) |-> !writeback.valid)
    else begin
        $error("register write within two cycles of a redirect");
        failCount++;
    end

endmodule

bind branchCore branchCoreSva branchCoreSva_i (
    .Clock     (Clock),
    .reset     (reset),
    .axiReq    (axiReq),
    .axiRsp    (axiRsp),
    .redirect  (redirect),
    .writeback (writeback)
);

`default_nettype wire

//--- sim/branchCore_testdata.txt
# M word data: program word | S 0 0: start, wait for halt
# C 0 exp: status | P 0 exp: PC | R reg exp: register value
# ldi chain with r0 base, negative C and forwarded base
M 000 08800005
M 001 0907FFFD
M 002 0988000A
M 003 0A1FFFEC
# taken zero, nonzero, plus, minus with squashed r13/r14 markers
M 004 98000002
M 005 0E800111
M 006 0F000222
M 007 98880002
M 008 0E800111
M 009 0F000222
M 00A 98100002
M 00B 0E800111
M 00C 0F000222
M 00D 99180002
M 00E 0E800111
M 00F 0F000222
# not taken zero, nonzero, plus, minus, each adding 1 to r5
M 010 99000001
M 011 0AA80001
M 012 98080001
M 013 0AA80001
M 014 99100001
M 015 0AA80001
M 016 98980001
M 017 0AA80001
# ldi then branch on the same register
M 018 0B000007
M 019 9B000001
M 01A 0C000055
M 01B 0B87FFFF
M 01C 9B980001
M 01D 0C800099
M 01E D8000000
S 0 0
C 0 00000002
P 0 0000001E
R 1 00000005
R 2 FFFFFFFD
R 3 0000000F
R 4 FFFFFFFB
R 5 00000004
R 6 00000007
R 7 FFFFFFFF
R 8 00000055
R 9 00000000
R D 00000000
R E 00000000
# second program must run from word 0
M 000 0D000123
M 001 08880001
M 002 D8000000
S 0 0
C 0 00000002
P 0 00000002
R A 00000123
R 1 00000006
